/* filelist.f */
verilog/ctrlPkg.sv
verilog/perfCounters.sv
verilog/spiMaster.sv
verilog/gpioPort.sv
verilog/controlRegs.sv
verilog/ctrlSubsystem.sv
bench/ctrlSubsystemTb.sv

/* Bender.yml */
package:
  name: ctrl_subsystem

sources:
  - verilog/ctrlPkg.sv
  - verilog/perfCounters.sv
  - verilog/spiMaster.sv
  - verilog/gpioPort.sv
  - verilog/controlRegs.sv
  - verilog/ctrlSubsystem.sv
  - target: test
    files:
      - bench/ctrlSubsystemTb.sv

/* bench/ctrlSubsystemTb.sv */
module ctrlSubsystemTb;

    localparam int numUops = 4;
    localparam int numWbs = 4;
    localparam int numRandWrites = 24;
    localparam int counterCycles = 64;
    // Upper bounds on the cost of one access in cycles
    localparam int readCycles = 4;
    localparam int writeCycles = 2;
    localparam int maxGpioDelay = 18;
    localparam int timeoutCycles = 2 * (8 + 17 * readCycles
        + numRandWrites * (writeCycles + readCycles)
        + 3 * (writeCycles + 2 * 32 + 8 + readCycles)
        + 2 * writeCycles + maxGpioDelay + 8 + 3 * readCycles
        + counterCycles + 12 * readCycles + 2 + 2 * readCycles);

    logic clk;
    logic rst;
    ctrlPkg::regWrite wr;
    logic rdEn;
    ctrlPkg::regAddr rdAddr;
    ctrlPkg::dataWord rdData;
    logic rdValid;
    logic [numUops-1:0] fetchValid;
    logic [numUops-1:0] commitValid;
    logic [numWbs-1:0] wbValid;
    ctrlPkg::perfEvents events;
    logic irqTaken;
    ctrlPkg::irqInfo irq;
    ctrlPkg::dataWord irqAddr;
    ctrlPkg::gpioWord gpioOe;
    ctrlPkg::gpioWord gpioOut;
    ctrlPkg::gpioWord gpioIn;
    logic spiClk;
    logic spiMosi;
    logic spiMiso;
    logic ioBusy;

    // Expected contents of the 32-bit bank
    ctrlPkg::dataWord model [16];
    logic [31:0] lfsrState;
    int valueErrors = 0;
    int protoErrors = 0;
    int cycleCount = 0;
    // Cycle of the most recent read issue
    int issueCycle;

    // Shift port looped back on itself
    assign spiMiso = spiMosi;

    ctrlSubsystem #(.numUops(numUops), .numWbs(numWbs)) ctrlSubsystem_inst (
        .clk(clk), .rst(rst), .wr(wr), .rdEn(rdEn), .rdAddr(rdAddr),
        .rdData(rdData), .rdValid(rdValid), .fetchValid(fetchValid),
        .commitValid(commitValid), .wbValid(wbValid), .events(events),
        .irqTaken(irqTaken), .irq(irq), .irqAddr(irqAddr), .gpioOe(gpioOe),
        .gpioOut(gpioOut), .gpioIn(gpioIn), .spiClk(spiClk), .spiMosi(spiMosi),
        .spiMiso(spiMiso), .ioBusy(ioBusy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Read data valid two sampled edges after the strobe
    readLatency: assert property (@(posedge clk) disable iff (rst) rdEn |-> ##2 rdValid)
        else begin
            protoErrors++;
            $display("[ERROR] %0t rdValid got %b expected 1", $time, rdValid);
        end

    // No valid without a matching strobe
    readOrigin: assert property (@(posedge clk) disable iff (rst) rdValid |-> $past(rdEn, 2))
        else begin
            protoErrors++;
            $display("[ERROR] %0t rdValid got 1 expected 0", $time);
        end

    // Serial clock high for one cycle at a time
    spiClkWidth: assert property (@(posedge clk) disable iff (rst) spiClk |=> !spiClk)
        else begin
            protoErrors++;
            $display("[ERROR] %0t spiClk got 1 expected 0", $time);
        end

    spiClkBusy: assert property (@(posedge clk) disable iff (rst) spiClk |-> ioBusy)
        else begin
            protoErrors++;
            $display("[ERROR] %0t ioBusy got 0 expected 1", $time);
        end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randomBits(int n);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < n; i++) begin
            result = {result[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
        end
        return result;
    endfunction

    // Old bytes kept where the mask is clear
    function automatic logic [31:0] maskedMerge(logic [31:0] oldWord, logic [31:0] newWord,
                                                logic [3:0] mask);
        logic [31:0] laneBits;
        laneBits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (oldWord & ~laneBits) | (newWord & laneBits);
    endfunction

    function automatic logic [31:0] rotateLeft(logic [31:0] word, int n);
        logic [63:0] both;
        both = {word, word} << n;
        return both[63:32];
    endfunction

    function automatic int countOnes(logic [31:0] v);
        int total;
        total = 0;
        for (int i = 0; i < 32; i++) begin
            if (v[i])
                total++;
        end
        return total;
    endfunction

    task automatic checkEqual(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Called 2 units after an edge, returns the same way
    task automatic writeReg(logic [4:0] idx, logic [3:0] mask, logic [31:0] data);
        wr = '{1'b1, {2'b00, idx}, mask, data};
        @(posedge clk);
        #2;
        wr = '0;
    endtask

    task automatic readReg(logic [6:0] addr, output logic [31:0] data);
        int waitCycles;
        rdEn = 1'b1;
        rdAddr = addr;
        issueCycle = cycleCount;
        @(posedge clk);
        #2;
        rdEn = 1'b0;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #2;
            waitCycles++;
        end while (!rdValid && waitCycles < readCycles);
        assert (rdValid) else begin
            protoErrors++;
            $display("Read of address %0d returned no valid data", addr);
        end
        data = rdData;
    endtask

    task automatic readCheck(logic [4:0] idx, logic [31:0] exp);
        logic [31:0] got;
        readReg({2'b00, idx}, got);
        checkEqual($sformatf("rdData[reg %0d]", idx), got, exp);
    endtask

    initial begin
        logic [4:0] idx;
        logic [3:0] mask;
        logic [31:0] data;
        logic [31:0] rnd;
        logic [31:0] loaded;
        logic [31:0] ctrlWord;
        logic [7:0] delay;
        logic [7:0] setBits;
        logic [7:0] clrBits;
        logic [7:0] expByte;
        logic prevClk;
        logic seenBusy;
        logic [31:0] startVal [6];
        logic [31:0] endVal [6];
        int expCount [6];
        int startIssue;
        int nBits;
        int pulses;
        int busyCycles;
        int waitCycles;

        lfsrState = 32'h7f144a2a;
        rst = 1'b1;
        wr = '0;
        rdEn = 1'b0;
        rdAddr = '0;
        fetchValid = '0;
        commitValid = '0;
        wbValid = '0;
        events = '0;
        irqTaken = 1'b0;
        irq = '0;
        gpioIn = '0;
        for (int i = 0; i < 16; i++)
            model[i] = (i >= 8) ? i * 256 : 0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset values of the whole bank and the pins
        for (int i = 0; i < 16; i++)
            readCheck(5'(i), model[i]);
        checkEqual("irqAddr", irqAddr, 32'h0);
        checkEqual("gpioOe", {16'h0, gpioOe}, 32'h0);
        checkEqual("gpioOut", {16'h0, gpioOut}, 32'h0);
        checkEqual("spiClk", {31'h0, spiClk}, 32'h0);
        checkEqual("ioBusy", {31'h0, ioBusy}, 32'h0);

        // Random byte-masked writes over the plain registers
        for (int n = 0; n < numRandWrites; n++) begin
            rnd = randomBits(4);
            idx = rnd[3] ? {2'b01, rnd[2:0]} : (rnd[0] ? 5'd3 : 5'd0);
            rnd = randomBits(4);
            mask = rnd[3:0];
            data = randomBits(32);
            writeReg(idx, mask, data);
            model[idx] = maskedMerge(model[idx], data, mask);
            readCheck(idx, model[idx]);
            // Handler register drives irqAddr
            checkEqual("irqAddr", irqAddr, model[0]);
        end

        // Loopback transfers of 8, 16 and 32 bits
        for (int t = 0; t < 3; t++) begin
            nBits = 8 << t;
            mask = (t == 0) ? 4'b1000 : ((t == 1) ? 4'b1100 : 4'b1111);
            data = randomBits(32);
            // Shift register takes the merged word
            loaded = maskedMerge(model[4], data, mask);
            writeReg(ctrlPkg::regSpi, mask, data);
            pulses = 0;
            busyCycles = 0;
            waitCycles = 0;
            prevClk = 1'b0;
            seenBusy = 1'b0;
            do begin
                @(posedge clk);
                #2;
                waitCycles++;
                if (ioBusy) begin
                    busyCycles++;
                    seenBusy = 1'b1;
                end
                if (spiClk && !prevClk) begin
                    // MSB first on mosi
                    if (pulses < 32)
                        checkEqual("spiMosi", {31'h0, spiMosi}, {31'h0, loaded[31 - pulses]});
                    pulses++;
                end
                prevClk = spiClk;
            end while ((ioBusy || !seenBusy) && waitCycles < 2 * nBits + 8);
            checkEqual("spiClk pulses", pulses, nBits);
            checkEqual("ioBusy cycles", busyCycles, 2 * nBits);
            model[4] = rotateLeft(loaded, nBits);
            readCheck(ctrlPkg::regSpi, model[4]);
        end

        // GPIO delay with set and clear masks
        rnd = randomBits(4);
        delay = 8'd3 + {4'h0, rnd[3:0]};
        rnd = randomBits(16);
        setBits = rnd[7:0];
        clrBits = rnd[15:8];
        ctrlWord = {8'h00, clrBits, setBits, delay};
        writeReg(ctrlPkg::regGpioCtrl, 4'b0111, ctrlWord);
        model[6] = maskedMerge(model[6], ctrlWord, 4'b0111);
        data = randomBits(32);
        writeReg(ctrlPkg::regGpioOut, 4'b1111, data);
        busyCycles = 0;
        waitCycles = 0;
        seenBusy = 1'b0;
        do begin
            @(posedge clk);
            #2;
            waitCycles++;
            if (ioBusy) begin
                busyCycles++;
                seenBusy = 1'b1;
                // Written byte held while the delay runs
                checkEqual("gpioOut", {16'h0, gpioOut}, {16'h0, data[31:16]});
            end
        end while ((ioBusy || !seenBusy) && waitCycles < maxGpioDelay + 8);
        checkEqual("ioBusy cycles", busyCycles, {24'h0, delay});
        @(posedge clk);
        #2;
        expByte = (data[31:24] | setBits) & ~clrBits;
        model[5] = {expByte, data[23:0]};
        checkEqual("gpioOut", {16'h0, gpioOut}, {16'h0, model[5][31:16]});
        checkEqual("gpioOe", {16'h0, gpioOe}, {16'h0, model[5][15:0]});
        readCheck(ctrlPkg::regGpioOut, model[5]);
        readCheck(ctrlPkg::regGpioCtrl, model[6]);
        rnd = randomBits(16);
        gpioIn = rnd[15:0];
        readCheck(ctrlPkg::regGpioIn, {16'h0, gpioIn});

        // Counter snapshot with idle events
        for (int c = 0; c < 6; c++) begin
            readReg({3'b010, 3'(c), 1'b0}, startVal[c]);
            if (c == 0)
                startIssue = issueCycle;
            expCount[c] = 0;
        end
        for (int k = 0; k < counterCycles; k++) begin
            rnd = randomBits(numUops);
            fetchValid = rnd[numUops-1:0];
            rnd = randomBits(numUops);
            commitValid = rnd[numUops-1:0];
            rnd = randomBits(numWbs);
            wbValid = rnd[numWbs-1:0];
            rnd = randomBits(3);
            events = rnd[2:0];
            expCount[1] += countOnes({28'h0, fetchValid});
            expCount[2] += countOnes({28'h0, wbValid});
            // Flushed commits are not counted
            if (!events.mispredFlush)
                expCount[3] += countOnes({28'h0, commitValid});
            if (events.branchMispred)
                expCount[4]++;
            if (events.comBranch)
                expCount[5]++;
            @(posedge clk);
            #2;
        end
        fetchValid = '0;
        commitValid = '0;
        wbValid = '0;
        events = '0;
        for (int c = 0; c < 6; c++) begin
            readReg({3'b010, 3'(c), 1'b0}, endVal[c]);
            if (c == 0)
                expCount[0] = issueCycle - startIssue;
        end
        for (int c = 0; c < 6; c++)
            checkEqual($sformatf("counter %0d delta", c), endVal[c] - startVal[c], expCount[c]);

        // Interrupt capture
        irq.src = randomBits(32);
        irq.memAddr = randomBits(32);
        rnd = randomBits(2);
        irq.flags = rnd[1:0];
        irqTaken = 1'b1;
        @(posedge clk);
        #2;
        irqTaken = 1'b0;
        model[1] = irq.src;
        model[2] = {irq.memAddr[31:2], irq.flags};
        readCheck(ctrlPkg::regIrqSrc, model[1]);
        readCheck(ctrlPkg::regIrqAddr, model[2]);

        $display("Checks done with %0d value errors and %0d protocol errors",
                 valueErrors, protoErrors);
        if (valueErrors + protoErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verilog/ctrlSubsystem.sv */
module ctrlSubsystem #(
    parameter int numUops = 4,
    parameter int numWbs = 4
) (
    input logic clk,
    input logic rst,
    input ctrlPkg::regWrite wr,
    input logic rdEn,
    input ctrlPkg::regAddr rdAddr,
    output ctrlPkg::dataWord rdData,
    output logic rdValid,
    input logic [numUops-1:0] fetchValid,
    input logic [numUops-1:0] commitValid,
    input logic [numWbs-1:0] wbValid,
    input ctrlPkg::perfEvents events,
    input logic irqTaken,
    input ctrlPkg::irqInfo irq,
    output ctrlPkg::dataWord irqAddr,
    output ctrlPkg::gpioWord gpioOe,
    output ctrlPkg::gpioWord gpioOut,
    input ctrlPkg::gpioWord gpioIn,
    output logic spiClk,
    output logic spiMosi,
    input logic spiMiso,
    output logic ioBusy
);

    ctrlPkg::perfBank counters;
    // Register block to SPI
    logic spiStart;
    logic [5:0] spiBits;
    ctrlPkg::dataWord spiLoad;
    ctrlPkg::dataWord spiData;
    logic spiBusy;
    // Register block to GPIO
    logic gpioOutWe;
    logic gpioCtrlWe;
    ctrlPkg::byteMask wrMask;
    ctrlPkg::dataWord wrData;
    ctrlPkg::dataWord gpioOutReg;
    ctrlPkg::dataWord gpioCtrlReg;
    logic gpioBusy;

    controlRegs controlRegs_inst (
        .clk(clk), .rst(rst), .wr(wr), .rdEn(rdEn), .rdAddr(rdAddr),
        .irqTaken(irqTaken), .irq(irq), .gpioIn(gpioIn), .counters(counters),
        .spiData(spiData), .gpioOutReg(gpioOutReg), .gpioCtrlReg(gpioCtrlReg),
        .rdData(rdData), .rdValid(rdValid), .irqAddr(irqAddr),
        .spiStart(spiStart), .spiBits(spiBits), .spiLoad(spiLoad),
        .gpioOutWe(gpioOutWe), .gpioCtrlWe(gpioCtrlWe),
        .wrMask(wrMask), .wrData(wrData)
    );

    perfCounters #(.numUops(numUops), .numWbs(numWbs)) perfCounters_inst (
        .clk(clk), .rst(rst), .fetchValid(fetchValid), .commitValid(commitValid),
        .wbValid(wbValid), .events(events), .counters(counters)
    );

    spiMaster spiMaster_inst (
        .clk(clk), .rst(rst), .start(spiStart), .bits(spiBits), .load(spiLoad),
        .miso(spiMiso), .sclk(spiClk), .mosi(spiMosi), .data(spiData), .busy(spiBusy)
    );

    gpioPort gpioPort_inst (
        .clk(clk), .rst(rst), .outWe(gpioOutWe), .ctrlWe(gpioCtrlWe),
        .mask(wrMask), .wdata(wrData), .oe(gpioOe), .out(gpioOut),
        .outReg(gpioOutReg), .ctrlReg(gpioCtrlReg), .busy(gpioBusy)
    );

    // Any I/O activity in flight
    assign ioBusy = spiBusy | gpioBusy;

endmodule

/* verilog/controlRegs.sv */
module controlRegs (
    input logic clk,
    input logic rst,
    input ctrlPkg::regWrite wr,
    input logic rdEn,
    input ctrlPkg::regAddr rdAddr,
    input logic irqTaken,
    input ctrlPkg::irqInfo irq,
    input ctrlPkg::gpioWord gpioIn,
    input ctrlPkg::perfBank counters,
    input ctrlPkg::dataWord spiData,
    input ctrlPkg::dataWord gpioOutReg,
    input ctrlPkg::dataWord gpioCtrlReg,
    output ctrlPkg::dataWord rdData,
    output logic rdValid,
    output ctrlPkg::dataWord irqAddr,
    output logic spiStart,
    output logic [5:0] spiBits,
    output ctrlPkg::dataWord spiLoad,
    output logic gpioOutWe,
    output logic gpioCtrlWe,
    output ctrlPkg::byteMask wrMask,
    output ctrlPkg::dataWord wrData
);

    // Registered access strobes
    ctrlPkg::regWrite wrReg;
    logic rdEnReg;
    ctrlPkg::regAddr rdAddrReg;

    // Local storage: 0 to 3, then the RAM map 8 to 15
    ctrlPkg::dataWord lowRegs [4];
    ctrlPkg::dataWord ramMap [8];

    // Write decode
    logic wrLocal;
    logic [4:0] wrIdx;

    // Read path
    ctrlPkg::counter64 cntSel;
    ctrlPkg::dataWord rdMux;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrReg <= '0;
            rdEnReg <= 1'b0;
        end else begin
            wrReg <= wr;
            rdEnReg <= rdEn;
        end
    end

    always_ff @(posedge clk) begin
        rdAddrReg <= rdAddr;
    end

    // Counter bank writes are dropped here
    assign wrLocal = wrReg.en && !wrReg.addr[5];
    assign wrIdx = wrReg.addr[4:0];

    // SPI start on any regSpi write
    assign spiStart = wrLocal && (wrIdx == ctrlPkg::regSpi);
    assign spiLoad = ctrlPkg::mergeBytes(spiData, wrReg.data, wrReg.mask);

    // Transfer length from the byte mask, zero just stores
    always_comb begin
        case (wrReg.mask)
            4'b1111: spiBits = 6'd32;
            4'b1100: spiBits = 6'd16;
            4'b1000: spiBits = 6'd8;
            default: spiBits = 6'd0;
        endcase
    end

    // GPIO registers live in the port
    assign gpioOutWe = wrLocal && (wrIdx == ctrlPkg::regGpioOut);
    assign gpioCtrlWe = wrLocal && (wrIdx == ctrlPkg::regGpioCtrl);
    assign wrMask = wrReg.mask;
    assign wrData = wrReg.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++)
                lowRegs[i] <= '0;
            // RAM map resets to index << 8
            for (int i = 0; i < 8; i++)
                ramMap[i] <= ctrlPkg::dataWord'((ctrlPkg::regRamMapBase + i) << 8);
        end else begin
            if (wrLocal && wrIdx < ctrlPkg::regSpi)
                lowRegs[wrIdx[1:0]] <= ctrlPkg::mergeBytes(lowRegs[wrIdx[1:0]],
                                                           wrReg.data, wrReg.mask);
            if (wrLocal && !wrIdx[4] && wrIdx >= ctrlPkg::regRamMapBase)
                ramMap[wrIdx[2:0]] <= ctrlPkg::mergeBytes(ramMap[wrIdx[2:0]],
                                                          wrReg.data, wrReg.mask);

            // Interrupt capture overrides a same-cycle write
            if (irqTaken) begin
                lowRegs[ctrlPkg::regIrqSrc[1:0]] <= irq.src;
                lowRegs[ctrlPkg::regIrqAddr[1:0]] <= {irq.memAddr[31:2], irq.flags};
            end
        end
    end

    // Handler address straight out
    assign irqAddr = lowRegs[ctrlPkg::regIrqHandler[1:0]];

    // Counter select, 6 and 7 are empty
    always_comb begin
        case (rdAddrReg[3:1])
            3'd0: cntSel = counters.cycles;
            3'd1: cntSel = counters.fetched;
            3'd2: cntSel = counters.executed;
            3'd3: cntSel = counters.committed;
            3'd4: cntSel = counters.mispredicts;
            3'd5: cntSel = counters.branches;
            default: cntSel = '0;
        endcase
    end

    always_comb begin
        if (rdAddrReg[5]) begin
            // Bit 0 picks the upper half
            rdMux = rdAddrReg[0] ? cntSel[63:32] : cntSel[31:0];
        end else begin
            case (rdAddrReg[4:0])
                ctrlPkg::regIrqHandler,
                ctrlPkg::regIrqSrc,
                ctrlPkg::regIrqAddr,
                ctrlPkg::regStatus: rdMux = lowRegs[rdAddrReg[1:0]];
                ctrlPkg::regSpi: rdMux = spiData;
                ctrlPkg::regGpioOut: rdMux = gpioOutReg;
                ctrlPkg::regGpioCtrl: rdMux = gpioCtrlReg;
                ctrlPkg::regGpioIn: rdMux = {16'b0, gpioIn};
                // RAM map, 16 and up read zero
                default: rdMux = rdAddrReg[4] ? '0 : ramMap[rdAddrReg[2:0]];
            endcase
        end
    end

    // One-cycle read valid
    always_ff @(posedge clk) begin
        if (rst)
            rdValid <= 1'b0;
        else
            rdValid <= rdEnReg;
    end

    always_ff @(posedge clk) begin
        if (rdEnReg)
            rdData <= rdMux;
    end

endmodule

/* verilog/gpioPort.sv */
module gpioPort (
    input logic clk,
    input logic rst,
    input logic outWe,
    input logic ctrlWe,
    input ctrlPkg::byteMask mask,
    input ctrlPkg::dataWord wdata,
    output ctrlPkg::gpioWord oe,
    output ctrlPkg::gpioWord out,
    output ctrlPkg::dataWord outReg,
    output ctrlPkg::dataWord ctrlReg,
    output logic busy
);

    // Cycles left before the upper byte update
    logic [7:0] delayCnt;
    logic [7:0] setMask;
    logic [7:0] clrMask;

    // Control fields: delay 7:0, set 15:8, clear 23:16
    assign setMask = ctrlReg[15:8];
    assign clrMask = ctrlReg[23:16];

    always_ff @(posedge clk) begin
        if (rst) begin
            outReg <= '0;
            ctrlReg <= '0;
            delayCnt <= '0;
        end else begin
            if (ctrlWe)
                ctrlReg <= ctrlPkg::mergeBytes(ctrlReg, wdata, mask);

            // Output write restarts the delay
            if (outWe) begin
                outReg <= ctrlPkg::mergeBytes(outReg, wdata, mask);
                delayCnt <= ctrlReg[7:0];
            end else if (delayCnt != 8'd0) begin
                delayCnt <= delayCnt - 8'd1;
            end

            // Expired delay applies set then clear
            // A direct write of byte 3 takes priority
            if (delayCnt == 8'd0 && !(outWe && mask[3]))
                outReg[31:24] <= (outReg[31:24] | setMask) & ~clrMask;
        end
    end

    // Pins straight from the output register
    assign oe = outReg[15:0];
    assign out = outReg[31:16];
    assign busy = (delayCnt != 8'd0);

endmodule

/* verilog/spiMaster.sv */
module spiMaster (
    input logic clk,
    input logic rst,
    input logic start,
    input logic [5:0] bits,
    input ctrlPkg::dataWord load,
    input logic miso,
    output logic sclk,
    output logic mosi,
    output ctrlPkg::dataWord data,
    output logic busy
);

    ctrlPkg::spiState state;
    ctrlPkg::dataWord shiftReg;
    // Bits still to clock
    logic [5:0] bitCnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrlPkg::idle;
            sclk <= 1'b0;
            mosi <= 1'b0;
            bitCnt <= '0;
            shiftReg <= '0;
        end else begin
            case (state)
                ctrlPkg::idle: begin
                    // Start loads the word, zero length only stores it
                    if (start) begin
                        shiftReg <= load;
                        mosi <= load[31];
                        bitCnt <= bits;
                        if (bits != 6'd0)
                            state <= ctrlPkg::clockLow;
                    end
                end
                ctrlPkg::clockLow: begin
                    // Rising edge, sample miso into bit 0
                    sclk <= 1'b1;
                    shiftReg <= {shiftReg[30:0], miso};
                    bitCnt <= bitCnt - 6'd1;
                    state <= ctrlPkg::clockHigh;
                end
                ctrlPkg::clockHigh: begin
                    // Falling edge, next bit out
                    sclk <= 1'b0;
                    mosi <= shiftReg[31];
                    if (bitCnt == 6'd0)
                        state <= ctrlPkg::idle;
                    else
                        state <= ctrlPkg::clockLow;
                end
                default: state <= ctrlPkg::idle;
            endcase
        end
    end

    assign data = shiftReg;
    // Busy for 2n cycles per transfer
    assign busy = (state != ctrlPkg::idle);

endmodule

/* verilog/perfCounters.sv */
module perfCounters #(
    parameter int numUops = 4,
    parameter int numWbs = 4
) (
    input logic clk,
    input logic rst,
    input logic [numUops-1:0] fetchValid,
    input logic [numUops-1:0] commitValid,
    input logic [numWbs-1:0] wbValid,
    input ctrlPkg::perfEvents events,
    output ctrlPkg::perfBank counters
);

    // Per-cycle increments
    ctrlPkg::counter64 fetchCnt;
    ctrlPkg::counter64 commitCnt;
    ctrlPkg::counter64 wbCnt;

    // Population counts of the slot vectors
    always_comb begin
        fetchCnt = '0;
        commitCnt = '0;
        for (int i = 0; i < numUops; i++) begin
            fetchCnt = fetchCnt + {63'b0, fetchValid[i]};
            commitCnt = commitCnt + {63'b0, commitValid[i]};
        end
    end

    always_comb begin
        wbCnt = '0;
        for (int i = 0; i < numWbs; i++)
            wbCnt = wbCnt + {63'b0, wbValid[i]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counters <= '0;
        end else begin
            // Free-running cycle count
            counters.cycles <= counters.cycles + 64'd1;
            counters.fetched <= counters.fetched + fetchCnt;
            counters.executed <= counters.executed + wbCnt;
            // Flushed commits don't retire
            if (!events.mispredFlush)
                counters.committed <= counters.committed + commitCnt;
            if (events.branchMispred)
                counters.mispredicts <= counters.mispredicts + 64'd1;
            if (events.comBranch)
                counters.branches <= counters.branches + 64'd1;
        end
    end

endmodule

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    // Register address
    // Bit 5 selects the counter bank, bits 3:1 the counter, bit 0 the half
    typedef logic [6:0] regAddr;
    typedef logic [31:0] dataWord;
    // One enable per byte lane
    typedef logic [3:0] byteMask;
    typedef logic [63:0] counter64;
    typedef logic [1:0] irqFlags;
    typedef logic [15:0] gpioWord;

    // One write request on the register bus, 44 bits
    typedef struct packed {
        logic en;
        regAddr addr;
        byteMask mask;
        dataWord data;
    } regWrite;

    // Interrupt information from the core
    typedef struct packed {
        dataWord src;
        dataWord memAddr;
        irqFlags flags;
    } irqInfo;

    // Single-bit pipeline events
    typedef struct packed {
        logic mispredFlush;
        logic branchMispred;
        logic comBranch;
    } perfEvents;

    // Counter bank, cycles in the top bits
    typedef struct packed {
        counter64 cycles;
        counter64 fetched;
        counter64 executed;
        counter64 committed;
        counter64 mispredicts;
        counter64 branches;
    } perfBank;

    // Shift engine phases
    typedef enum logic [1:0] {
        idle,
        clockLow,
        clockHigh
    } spiState;

    // 32-bit bank indices
    localparam logic [4:0] regIrqHandler = 5'd0;
    localparam logic [4:0] regIrqSrc = 5'd1;
    localparam logic [4:0] regIrqAddr = 5'd2;
    localparam logic [4:0] regStatus = 5'd3;
    localparam logic [4:0] regSpi = 5'd4;
    localparam logic [4:0] regGpioOut = 5'd5;
    localparam logic [4:0] regGpioCtrl = 5'd6;
    localparam logic [4:0] regGpioIn = 5'd7;
    localparam logic [4:0] regRamMapBase = 5'd8;

    // Byte-lane merge of a write into an old word
    function automatic dataWord mergeBytes(dataWord oldWord, dataWord newWord, byteMask mask);
        dataWord result;
        result = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                result[b*8 +: 8] = newWord[b*8 +: 8];
        end
        return result;
    endfunction

endpackage
